/* Bender.yml */
package:
  name: capture_top

sources:
  - include_dirs:
      - source
    files:
      - source/cap_pkg.sv
      - source/frame_ram.sv
      - source/mem_arbiter.sv
      - source/pixel_capture.sv
      - source/frame_copy.sv
      - source/readout_reader.sv
      - source/capture_top.sv
      - target: test
        files:
          - sim/tb_capture_top.sv

/* project.f */
+incdir+source
source/cap_pkg.sv
source/frame_ram.sv
source/mem_arbiter.sv
source/pixel_capture.sv
source/frame_copy.sv
source/readout_reader.sv
source/capture_top.sv
sim/tb_capture_top.sv

/* sim/capture_patterns.txt */
// Word 0: number of readout windows; next 32 words: frame 1 then frame 2 pixels
// Then one line per window: snapshot offset, word count, frame (0 = frame 1, 1 = frame 2)
6
// frame 1
a1b2c3
102030
ff0000
00ff00
0000ff
123456
abcdef
fedcba
0f0f0f
f0f0f0
55aa55
aa55aa
777777
010203
c0ffee
beef01
// frame 2
314159
265358
979323
846264
338327
950288
419716
939937
510582
097494
459230
781640
628620
899862
803482
534211
// windows
3 4 0
f 1 0
8 8 0
0 5 1
a 6 1
7 2 1

/* sim/tb_capture_top.sv */
`default_nettype none

`include "capture_params.svh"

module tb_capture_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME    = `CAP_FRAME_WORDS;
    localparam int WIN_BASE = 1 + 2 * FRAME;

    logic            ui_clk_i;
    logic            rst_n_i;
    logic            capture_i;
    logic            vsync_i;
    logic            de_i;
    cap_pkg::pixel_t rgb_i;
    logic            kick_i;
    cap_pkg::count_t read_addr_i;
    cap_pkg::count_t read_num_i;
    logic            capture_busy_o;
    logic            snapshot_ready_o;
    logic            readout_busy_o;
    logic            buf_we_o;
    cap_pkg::word_t  buf_dout_o;

    // Word 0 window count, then two frames, then window triples
    logic [31:0]    pat [0:63];
    cap_pkg::word_t got_q [$];
    int             num_win;
    int             test_err    = 0;
    int             pass_cnt    = 0;
    int             fail_cnt    = 0;
    int             cycle_cnt   = 0;
    int             cycle_limit = 0;
    int unsigned    seed_val;

    capture_top dut (
        .ui_clk_i         (ui_clk_i),
        .rst_n_i          (rst_n_i),
        .capture_i        (capture_i),
        .vsync_i          (vsync_i),
        .de_i             (de_i),
        .rgb_i            (rgb_i),
        .kick_i           (kick_i),
        .read_addr_i      (read_addr_i),
        .read_num_i       (read_num_i),
        .capture_busy_o   (capture_busy_o),
        .snapshot_ready_o (snapshot_ready_o),
        .readout_busy_o   (readout_busy_o),
        .buf_we_o         (buf_we_o),
        .buf_dout_o       (buf_dout_o)
    );

    always #20 ui_clk_i = ~ui_clk_i;

    always @(posedge ui_clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout: run exceeded %0d clock cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Pixels land in memory zero-extended to a full word
    function automatic cap_pkg::word_t expected_word(int frame, int idx);
        return cap_pkg::word_t'(pat[1 + frame * FRAME + idx][23:0]);
    endfunction

    task automatic arm_capture();
        @(posedge ui_clk_i);
        capture_i <= 1'b1;
        @(posedge ui_clk_i);
        capture_i <= 1'b0;
    endtask

    // de high with junk data, outside any captured frame
    task automatic drive_junk(int n);
        for (int i = 0; i < n; i++) begin
            @(posedge ui_clk_i);
            de_i  <= 1'b1;
            rgb_i <= 24'hdead00 + cap_pkg::pixel_t'(i);
        end
        @(posedge ui_clk_i);
        de_i <= 1'b0;
    endtask

    task automatic drive_frame(int frame, int max_gap);
        int gap;
        @(posedge ui_clk_i);
        vsync_i <= 1'b1;
        @(posedge ui_clk_i);
        vsync_i <= 1'b0;
        for (int i = 0; i < FRAME; i++) begin
            gap = $urandom_range(max_gap, 0);
            repeat (gap) begin
                @(posedge ui_clk_i);
                de_i <= 1'b0;
            end
            @(posedge ui_clk_i);
            de_i  <= 1'b1;
            rgb_i <= pat[1 + frame * FRAME + i][23:0];
        end
        @(posedge ui_clk_i);
        de_i <= 1'b0;
    endtask

    task automatic start_kick(int offset, int count);
        @(posedge ui_clk_i);
        kick_i      <= 1'b1;
        read_addr_i <= cap_pkg::count_t'(offset);
        read_num_i  <= cap_pkg::count_t'(count);
        @(posedge ui_clk_i);
        kick_i <= 1'b0;
    endtask

    task automatic collect_words();
        got_q.delete();
        do begin
            @(negedge ui_clk_i);
            if (buf_we_o) begin
                got_q.push_back(buf_dout_o);
            end
        end while (readout_busy_o);
    endtask

    // Snapshot must stay valid for as long as the readout runs
    task automatic watch_snapshot_hold();
        do begin
            @(negedge ui_clk_i);
            if (readout_busy_o && !snapshot_ready_o) begin
                $display("MISMATCH at %0t ns: snapshot_ready_o low during readout", $time);
                test_err++;
            end
        end while (readout_busy_o);
    endtask

    task automatic wait_snapshot_ready();
        do begin
            @(negedge ui_clk_i);
        end while (!snapshot_ready_o);
    endtask

    task automatic check_window(int offset, int count, int frame, string name);
        cap_pkg::word_t exp;
        if (got_q.size() != count) begin
            $display("MISMATCH at %0t ns: %s returned %0d words, expected %0d",
                     $time, name, got_q.size(), count);
            test_err++;
        end
        for (int i = 0; i < got_q.size() && i < count; i++) begin
            exp = expected_word(frame, offset + i);
            if (got_q[i] !== exp) begin
                $display("MISMATCH at %0t ns: %s word %0d got %h expected %h",
                         $time, name, i, got_q[i], exp);
                test_err++;
            end
        end
    endtask

    task automatic finish_test(string name);
        if (test_err == 0) begin
            pass_cnt++;
            $display("PASS  %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL  %s (%0d errors)", name, test_err);
        end
        test_err = 0;
    endtask

    task automatic run_window(int offset, int count, int frame, string name);
        start_kick(offset, count);
        collect_words();
        check_window(offset, count, frame, name);
        finish_test(name);
    endtask

    task automatic run_windows(int frame);
        int off;
        int cnt;
        for (int w = 0; w < num_win; w++) begin
            off = pat[WIN_BASE + 3 * w];
            cnt = pat[WIN_BASE + 3 * w + 1];
            if (pat[WIN_BASE + 3 * w + 2] == frame) begin
                run_window(off, cnt, frame,
                           $sformatf("window %0d offset %0d count %0d", w, off, cnt));
            end
        end
    endtask

    initial begin
        ui_clk_i    = 1'b0;
        rst_n_i     = 1'b0;
        capture_i   = 1'b0;
        vsync_i     = 1'b0;
        de_i        = 1'b0;
        rgb_i       = '0;
        kick_i      = 1'b0;
        read_addr_i = '0;
        read_num_i  = '0;
        seed_val    = $urandom(48);
        $readmemh("sim/capture_patterns.txt", pat);
        num_win = pat[0];
        // Two captures, all readouts, margin of four
        cycle_limit = 4 * (2 + num_win + 4) * FRAME * 6 + 100;

        repeat (4) @(posedge ui_clk_i);
        rst_n_i <= 1'b1;

        @(negedge ui_clk_i);
        if (capture_busy_o !== 1'b0 || snapshot_ready_o !== 1'b0 ||
            readout_busy_o !== 1'b0 || buf_we_o !== 1'b0) begin
            $display("MISMATCH at %0t ns: outputs not idle after reset", $time);
            test_err++;
        end
        finish_test("reset state");

        drive_junk(3);
        arm_capture();
        @(negedge ui_clk_i);
        if (capture_busy_o !== 1'b1) begin
            $display("MISMATCH at %0t ns: capture_busy_o low after arming", $time);
            test_err++;
        end
        drive_junk(3);
        drive_frame(0, 2);
        wait_snapshot_ready();
        if (capture_busy_o !== 1'b0) begin
            $display("MISMATCH at %0t ns: capture_busy_o high after frame", $time);
            test_err++;
        end
        run_window(0, FRAME, 0, "frame 1 capture and full readout");

        run_windows(0);

        // Second kick lands while busy and must be dropped
        start_kick(4, 6);
        fork
            collect_words();
            start_kick(1, 3);
        join
        check_window(4, 6, 0, "kick while busy");
        finish_test("kick while busy");

        // Back-to-back pixels stall the readout past the end of capture
        start_kick(0, FRAME);
        fork
            collect_words();
            watch_snapshot_hold();
            begin
                arm_capture();
                drive_frame(1, 0);
            end
        join
        check_window(0, FRAME, 0, "readout during frame 2 capture");
        finish_test("readout during frame 2 capture");

        do begin
            @(negedge ui_clk_i);
        end while (snapshot_ready_o);
        wait_snapshot_ready();
        run_window(0, FRAME, 1, "frame 2 full readout");
        run_windows(1);

        $display("Tests passed: %0d  failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/cap_pkg.sv */
`default_nettype none

`include "capture_params.svh"

package cap_pkg;

    typedef logic [`CAP_WORD_W-1:0]  word_t;
    typedef logic [`CAP_PIXEL_W-1:0] pixel_t;
    typedef logic [`CAP_ADDR_W-1:0]  addr_t;

    // Wide enough to hold the full frame length
    typedef logic [$clog2(`CAP_FRAME_WORDS+1)-1:0] count_t;

    typedef struct packed {
        logic  req;
        logic  we;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  rvalid;
        word_t rdata;
    } mem_rsp_t;

    typedef enum logic [1:0] {CAP_IDLE, CAP_ARMED, CAP_WRITING} capture_state_t;

    typedef enum logic [1:0] {COPY_IDLE, COPY_READ, COPY_WAIT, COPY_WRITE} copy_state_t;

endpackage

`default_nettype wire

/* source/capture_params.svh */
`ifndef CAPTURE_PARAMS_SVH
`define CAPTURE_PARAMS_SVH

// Memory word and pixel widths
`define CAP_WORD_W        32
`define CAP_PIXEL_W       24

// Shared frame memory address width
`define CAP_ADDR_W        7

// Pixels per captured frame
`define CAP_FRAME_WORDS   16

// Region bases inside the frame memory
`define CAP_CAPTURE_BASE  0
`define CAP_SNAPSHOT_BASE 64

`endif

/* source/capture_top.sv */
`default_nettype none

module capture_top (
    input  wire logic            ui_clk_i,
    input  wire logic            rst_n_i,
    input  wire logic            capture_i,
    input  wire logic            vsync_i,
    input  wire logic            de_i,
    input  wire cap_pkg::pixel_t rgb_i,
    input  wire logic            kick_i,
    input  wire cap_pkg::count_t read_addr_i,
    input  wire cap_pkg::count_t read_num_i,
    output logic                 capture_busy_o,
    output logic                 snapshot_ready_o,
    output logic                 readout_busy_o,
    output logic                 buf_we_o,
    output cap_pkg::word_t       buf_dout_o
);

    cap_pkg::mem_req_t cap_req;
    cap_pkg::mem_req_t copy_req;
    cap_pkg::mem_req_t rd_req;
    cap_pkg::mem_req_t ram_req;
    cap_pkg::mem_rsp_t copy_rsp;
    cap_pkg::mem_rsp_t rd_rsp;
    cap_pkg::word_t    ram_rdata;
    logic              copy_gnt;
    logic              rd_gnt;
    logic              capture_done;

    pixel_capture u_pixel_capture (
        .ui_clk_i       (ui_clk_i),
        .rst_n_i        (rst_n_i),
        .capture_i      (capture_i),
        .vsync_i        (vsync_i),
        .de_i           (de_i),
        .rgb_i          (rgb_i),
        .req_o          (cap_req),
        .capture_busy_o (capture_busy_o),
        .capture_done_o (capture_done)
    );

    frame_copy u_frame_copy (
        .ui_clk_i         (ui_clk_i),
        .rst_n_i          (rst_n_i),
        .capture_done_i   (capture_done),
        .readout_busy_i   (readout_busy_o),
        .gnt_i            (copy_gnt),
        .rsp_i            (copy_rsp),
        .req_o            (copy_req),
        .snapshot_ready_o (snapshot_ready_o)
    );

    readout_reader u_readout_reader (
        .ui_clk_i       (ui_clk_i),
        .rst_n_i        (rst_n_i),
        .kick_i         (kick_i),
        .read_addr_i    (read_addr_i),
        .read_num_i     (read_num_i),
        .gnt_i          (rd_gnt),
        .rsp_i          (rd_rsp),
        .req_o          (rd_req),
        .readout_busy_o (readout_busy_o),
        .buf_we_o       (buf_we_o),
        .buf_dout_o     (buf_dout_o)
    );

    // Capture never stalls, so its grant goes nowhere
    mem_arbiter u_mem_arbiter (
        .ui_clk_i    (ui_clk_i),
        .rst_n_i     (rst_n_i),
        .cap_req_i   (cap_req),
        .copy_req_i  (copy_req),
        .rd_req_i    (rd_req),
        .cap_gnt_o   (),
        .copy_gnt_o  (copy_gnt),
        .rd_gnt_o    (rd_gnt),
        .copy_rsp_o  (copy_rsp),
        .rd_rsp_o    (rd_rsp),
        .ram_req_o   (ram_req),
        .ram_rdata_i (ram_rdata)
    );

    frame_ram u_frame_ram (
        .ui_clk_i (ui_clk_i),
        .req_i    (ram_req),
        .rdata_o  (ram_rdata)
    );

endmodule

`default_nettype wire

/* source/frame_copy.sv */
`default_nettype none

`include "capture_params.svh"

module frame_copy (
    input  wire logic              ui_clk_i,
    input  wire logic              rst_n_i,
    input  wire logic              capture_done_i,
    input  wire logic              readout_busy_i,
    input  wire logic              gnt_i,
    input  wire cap_pkg::mem_rsp_t rsp_i,
    output cap_pkg::mem_req_t      req_o,
    output logic                   snapshot_ready_o
);

    localparam cap_pkg::count_t LAST_WORD = cap_pkg::count_t'(`CAP_FRAME_WORDS - 1);

    cap_pkg::copy_state_t state_q;
    cap_pkg::count_t      idx_q;
    cap_pkg::word_t       word_q;
    logic                 pending_q;
    logic                 start;

    // Never touch the snapshot while it is being read out
    assign start = (state_q == cap_pkg::COPY_IDLE) && pending_q && !readout_busy_i;

    always_ff @(posedge ui_clk_i) begin
        if (!rst_n_i) begin
            state_q          <= cap_pkg::COPY_IDLE;
            idx_q            <= '0;
            pending_q        <= 1'b0;
            snapshot_ready_o <= 1'b0;
        end else begin
            if (capture_done_i) begin
                pending_q <= 1'b1;
            end else if (start) begin
                pending_q <= 1'b0;
            end
            case (state_q)
                cap_pkg::COPY_IDLE: begin
                    if (start) begin
                        state_q          <= cap_pkg::COPY_READ;
                        idx_q            <= '0;
                        snapshot_ready_o <= 1'b0;
                    end
                end
                cap_pkg::COPY_READ: begin
                    if (gnt_i) begin
                        state_q <= cap_pkg::COPY_WAIT;
                    end
                end
                cap_pkg::COPY_WAIT: begin
                    if (rsp_i.rvalid) begin
                        state_q <= cap_pkg::COPY_WRITE;
                    end
                end
                cap_pkg::COPY_WRITE: begin
                    if (gnt_i) begin
                        if (idx_q == LAST_WORD) begin
                            state_q          <= cap_pkg::COPY_IDLE;
                            snapshot_ready_o <= 1'b1;
                        end else begin
                            state_q <= cap_pkg::COPY_READ;
                            idx_q   <= idx_q + 1'b1;
                        end
                    end
                end
                default: state_q <= cap_pkg::COPY_IDLE;
            endcase
        end
    end

    // Holding register for the word in flight
    always_ff @(posedge ui_clk_i) begin
        if (state_q == cap_pkg::COPY_WAIT && rsp_i.rvalid) begin
            word_q <= rsp_i.rdata;
        end
    end

    always_comb begin
        req_o = '0;
        case (state_q)
            cap_pkg::COPY_READ: begin
                req_o.req  = 1'b1;
                req_o.addr = cap_pkg::addr_t'(`CAP_CAPTURE_BASE) + cap_pkg::addr_t'(idx_q);
            end
            cap_pkg::COPY_WRITE: begin
                req_o.req   = 1'b1;
                req_o.we    = 1'b1;
                req_o.addr  = cap_pkg::addr_t'(`CAP_SNAPSHOT_BASE) + cap_pkg::addr_t'(idx_q);
                req_o.wdata = word_q;
            end
            default: req_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/frame_ram.sv */
`default_nettype none

`include "capture_params.svh"

module frame_ram (
    input  wire logic              ui_clk_i,
    input  wire cap_pkg::mem_req_t req_i,
    output cap_pkg::word_t         rdata_o
);

    localparam int unsigned DEPTH = 1 << `CAP_ADDR_W;

    cap_pkg::word_t mem [0:DEPTH-1];

    always_ff @(posedge ui_clk_i) begin
        if (req_i.req && req_i.we) begin
            mem[req_i.addr] <= req_i.wdata;
        end
    end

    // Registered read, one cycle behind the request
    always_ff @(posedge ui_clk_i) begin
        rdata_o <= mem[req_i.addr];
    end

endmodule

`default_nettype wire

/* source/mem_arbiter.sv */
`default_nettype none

module mem_arbiter (
    input  wire logic              ui_clk_i,
    input  wire logic              rst_n_i,
    input  wire cap_pkg::mem_req_t cap_req_i,
    input  wire cap_pkg::mem_req_t copy_req_i,
    input  wire cap_pkg::mem_req_t rd_req_i,
    output logic                   cap_gnt_o,
    output logic                   copy_gnt_o,
    output logic                   rd_gnt_o,
    output cap_pkg::mem_rsp_t      copy_rsp_o,
    output cap_pkg::mem_rsp_t      rd_rsp_o,
    output cap_pkg::mem_req_t      ram_req_o,
    input  wire cap_pkg::word_t    ram_rdata_i
);

    logic last_rd_q;
    logic copy_rd_q;
    logic rd_rd_q;

    // Capture first, then whichever of copy/readout waited longer
    always_comb begin
        cap_gnt_o  = cap_req_i.req;
        copy_gnt_o = !cap_req_i.req && copy_req_i.req && (!rd_req_i.req || last_rd_q);
        rd_gnt_o   = !cap_req_i.req && rd_req_i.req && (!copy_req_i.req || !last_rd_q);
    end

    always_comb begin
        if (cap_gnt_o) begin
            ram_req_o = cap_req_i;
        end else if (copy_gnt_o) begin
            ram_req_o = copy_req_i;
        end else if (rd_gnt_o) begin
            ram_req_o = rd_req_i;
        end else begin
            ram_req_o = '0;
        end
    end

    always_ff @(posedge ui_clk_i) begin
        if (!rst_n_i) begin
            last_rd_q <= 1'b0;
            copy_rd_q <= 1'b0;
            rd_rd_q   <= 1'b0;
        end else begin
            if (copy_gnt_o) begin
                last_rd_q <= 1'b0;
            end else if (rd_gnt_o) begin
                last_rd_q <= 1'b1;
            end
            // Read owner for the data coming back next cycle
            copy_rd_q <= copy_gnt_o && !copy_req_i.we;
            rd_rd_q   <= rd_gnt_o && !rd_req_i.we;
        end
    end

    always_comb begin
        copy_rsp_o.rvalid = copy_rd_q;
        copy_rsp_o.rdata  = ram_rdata_i;
        rd_rsp_o.rvalid   = rd_rd_q;
        rd_rsp_o.rdata    = ram_rdata_i;
    end

    a_one_grant: assert property (@(posedge ui_clk_i) disable iff (!rst_n_i)
        $onehot0({cap_gnt_o, copy_gnt_o, rd_gnt_o}));

    // Pixels have no back-pressure path
    a_cap_granted: assert property (@(posedge ui_clk_i) disable iff (!rst_n_i)
        cap_req_i.req |-> cap_gnt_o && (ram_req_o == cap_req_i));

endmodule

`default_nettype wire

/* source/pixel_capture.sv */
`default_nettype none

`include "capture_params.svh"

module pixel_capture (
    input  wire logic           ui_clk_i,
    input  wire logic           rst_n_i,
    input  wire logic           capture_i,
    input  wire logic           vsync_i,
    input  wire logic           de_i,
    input  wire cap_pkg::pixel_t rgb_i,
    output cap_pkg::mem_req_t   req_o,
    output logic                capture_busy_o,
    output logic                capture_done_o
);

    localparam cap_pkg::count_t LAST_PIX = cap_pkg::count_t'(`CAP_FRAME_WORDS - 1);

    cap_pkg::capture_state_t state_q;
    cap_pkg::count_t         pix_cnt_q;
    logic                    vsync_q;
    logic                    vsync_rise;
    logic                    pix_we;

    assign vsync_rise = vsync_i && !vsync_q;
    assign pix_we     = (state_q == cap_pkg::CAP_WRITING) && de_i;

    always_ff @(posedge ui_clk_i) begin
        if (!rst_n_i) begin
            state_q        <= cap_pkg::CAP_IDLE;
            pix_cnt_q      <= '0;
            vsync_q        <= 1'b0;
            capture_done_o <= 1'b0;
        end else begin
            vsync_q        <= vsync_i;
            capture_done_o <= 1'b0;
            case (state_q)
                cap_pkg::CAP_IDLE: begin
                    if (capture_i) begin
                        state_q <= cap_pkg::CAP_ARMED;
                    end
                end
                cap_pkg::CAP_ARMED: begin
                    // Frame boundary
                    if (vsync_rise) begin
                        state_q   <= cap_pkg::CAP_WRITING;
                        pix_cnt_q <= '0;
                    end
                end
                cap_pkg::CAP_WRITING: begin
                    if (pix_we) begin
                        pix_cnt_q <= pix_cnt_q + 1'b1;
                        if (pix_cnt_q == LAST_PIX) begin
                            state_q        <= cap_pkg::CAP_IDLE;
                            capture_done_o <= 1'b1;
                        end
                    end
                end
                default: state_q <= cap_pkg::CAP_IDLE;
            endcase
        end
    end

    always_comb begin
        req_o.req   = pix_we;
        req_o.we    = 1'b1;
        req_o.addr  = cap_pkg::addr_t'(`CAP_CAPTURE_BASE) + cap_pkg::addr_t'(pix_cnt_q);
        req_o.wdata = cap_pkg::word_t'(rgb_i);
    end

    assign capture_busy_o = (state_q != cap_pkg::CAP_IDLE);

    // Writes stay inside the capture region of the current frame
    a_write_in_frame: assert property (@(posedge ui_clk_i) disable iff (!rst_n_i)
        req_o.req |-> (state_q == cap_pkg::CAP_WRITING) && (pix_cnt_q <= LAST_PIX));

endmodule

`default_nettype wire

/* source/readout_reader.sv */
`default_nettype none

`include "capture_params.svh"

module readout_reader (
    input  wire logic              ui_clk_i,
    input  wire logic              rst_n_i,
    input  wire logic              kick_i,
    input  wire cap_pkg::count_t   read_addr_i,
    input  wire cap_pkg::count_t   read_num_i,
    input  wire logic              gnt_i,
    input  wire cap_pkg::mem_rsp_t rsp_i,
    output cap_pkg::mem_req_t      req_o,
    output logic                   readout_busy_o,
    output logic                   buf_we_o,
    output cap_pkg::word_t         buf_dout_o
);

    cap_pkg::count_t base_q;
    cap_pkg::count_t num_q;
    cap_pkg::count_t issued_q;
    cap_pkg::count_t returned_q;

    always_ff @(posedge ui_clk_i) begin
        if (!rst_n_i) begin
            readout_busy_o <= 1'b0;
            base_q         <= '0;
            num_q          <= '0;
            issued_q       <= '0;
            returned_q     <= '0;
        end else if (!readout_busy_o) begin
            // Kicks only land while idle
            if (kick_i) begin
                readout_busy_o <= (read_num_i != '0);
                base_q         <= read_addr_i;
                num_q          <= read_num_i;
                issued_q       <= '0;
                returned_q     <= '0;
            end
        end else begin
            if (gnt_i) begin
                issued_q <= issued_q + 1'b1;
            end
            if (rsp_i.rvalid) begin
                returned_q <= returned_q + 1'b1;
                if (returned_q == num_q - 1'b1) begin
                    readout_busy_o <= 1'b0;
                end
            end
        end
    end

    // Next read may go out while the previous one returns
    always_comb begin
        req_o.req   = readout_busy_o && (issued_q != num_q);
        req_o.we    = 1'b0;
        req_o.addr  = cap_pkg::addr_t'(`CAP_SNAPSHOT_BASE) + cap_pkg::addr_t'(base_q)
                    + cap_pkg::addr_t'(issued_q);
        req_o.wdata = '0;
    end

    assign buf_we_o   = rsp_i.rvalid;
    assign buf_dout_o = rsp_i.rdata;

endmodule

`default_nettype wire
